// ==== flist.f ====
+incdir+include
source/chan_pkg.sv
source/axil_regs.sv
source/chan_ctrl.sv
source/bch_encoder.sv
source/error_injector.sv
source/syndrome_check.sv
source/chan_top.sv
test/chan_sva.sv
test/tb_chan.sv

// ==== include/chan_macros.svh ====
`ifndef CHAN_MACROS_SVH
`define CHAN_MACROS_SVH

// BCH(15,5) code, corrects up to three errors
`define BCH_N          15
`define BCH_K          5
`define BCH_GEN        11'b10100110111

`define DATA_W         8

// AXI-lite bus
`define AXI_ADDR_W     8
`define AXI_DATA_W     32

`define LFSR_SEED      16'hACE1    // any non-zero value

// ------------------------------------------------------------------------
// register map
// ------------------------------------------------------------------------
`define REG_CTRL       8'h00       // start, bch_en, err_en
`define REG_DATA_IN    8'h04
`define REG_ERR_CNT    8'h08
`define REG_STATUS     8'h0C       // done, busy, err_detected
`define REG_CW0        8'h10
`define REG_CW1        8'h14
`define REG_DATA_OUT   8'h18

`endif

// ==== source/axil_regs.sv ====
`include "chan_macros.svh"

module axil_regs (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      s_axil_awvalid,
    input  logic [`AXI_ADDR_W-1:0]    s_axil_awaddr,
    input  logic [2:0]                s_axil_awprot,
    output logic                      s_axil_awready,
    input  logic                      s_axil_wvalid,
    input  logic [`AXI_DATA_W-1:0]    s_axil_wdata,
    input  logic [`AXI_DATA_W/8-1:0]  s_axil_wstrb,
    output logic                      s_axil_wready,
    input  logic                      s_axil_bready,
    output logic                      s_axil_bvalid,
    output logic [1:0]                s_axil_bresp,
    input  logic                      s_axil_arvalid,
    input  logic [`AXI_ADDR_W-1:0]    s_axil_araddr,
    input  logic [2:0]                s_axil_arprot,
    output logic                      s_axil_arready,
    input  logic                      s_axil_rready,
    output logic                      s_axil_rvalid,
    output logic [`AXI_DATA_W-1:0]    s_axil_rdata,
    output logic [1:0]                s_axil_rresp,

    input  logic                      busy,
    input  logic                      done,
    input  logic                      err_detected,
    input  chan_pkg::codeword_t       cw0,
    input  chan_pkg::codeword_t       cw1,
    input  chan_pkg::byte_t           data_out,

    output logic                      start,
    output logic                      bch_en,
    output logic                      err_en,
    output chan_pkg::byte_t           data_in,
    output chan_pkg::err_cnt_t        err_cnt
);

    import chan_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                    wr_en;
    logic                    rd_en;
    logic                    wr_hit;
    logic                    rd_hit;
    logic [`AXI_DATA_W-1:0]  rd_word;
    byte_t                   data_in_q;
    err_cnt_t                err_cnt_q;

    // accept only when the previous response has been taken
    assign s_axil_awready = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
    assign s_axil_wready  = s_axil_awready;
    assign s_axil_arready = s_axil_arvalid & ~s_axil_rvalid;
    assign wr_en          = s_axil_awready;
    assign rd_en          = s_axil_arready;

    assign data_in = data_in_q;
    assign err_cnt = err_en ? err_cnt_q : '0;   // no errors unless enabled

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    always_comb begin
        case (s_axil_awaddr)
            `REG_CTRL, `REG_DATA_IN, `REG_ERR_CNT, `REG_STATUS,
            `REG_CW0, `REG_CW1, `REG_DATA_OUT: wr_hit = ~s_axil_awprot[2];
            default: wr_hit = 1'b0;
        endcase
    end

    always_comb begin
        rd_hit  = ~s_axil_arprot[2];    // instruction fetches are refused
        rd_word = '0;
        case (s_axil_araddr)
            `REG_CTRL:     rd_word[2:1] = {err_en, bch_en};
            `REG_DATA_IN:  rd_word[`DATA_W-1:0] = data_in_q;
            `REG_ERR_CNT:  rd_word[7:0] = err_cnt_q;
            `REG_STATUS:   rd_word[2:0] = {err_detected & bch_en, busy, done};
            `REG_CW0:      rd_word[`BCH_N-1:0] = cw0;
            `REG_CW1:      rd_word[`BCH_N-1:0] = cw1;
            `REG_DATA_OUT: rd_word[`DATA_W-1:0] = data_out;
            default:       rd_hit = 1'b0;
        endcase
        if (!rd_hit) begin
            rd_word = '0;
        end
    end

    // ------------------------------------------------------------------------
    // control fields and responses
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start         <= 1'b0;
            bch_en        <= 1'b0;
            err_en        <= 1'b0;
            data_in_q     <= '0;
            err_cnt_q     <= '0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp  <= RESP_OKAY;
            s_axil_rvalid <= 1'b0;
            s_axil_rresp  <= RESP_OKAY;
        end else begin
            start <= 1'b0;  // single-cycle pulse
            if (wr_en && wr_hit && s_axil_wstrb[0]) begin
                case (s_axil_awaddr)
                    `REG_CTRL: begin
                        start  <= s_axil_wdata[0];
                        bch_en <= s_axil_wdata[1];
                        err_en <= s_axil_wdata[2];
                    end
                    `REG_DATA_IN: data_in_q <= s_axil_wdata[`DATA_W-1:0];
                    `REG_ERR_CNT: err_cnt_q <= s_axil_wdata[7:0];
                    default: ;  // read-only registers ignore writes
                endcase
            end

            if (wr_en) begin
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end

            if (rd_en) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_axil_rdata <= rd_word;    // held while rvalid waits
        end
    end

endmodule

// ==== source/bch_encoder.sv ====
`include "chan_macros.svh"

module bch_encoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  chan_pkg::info_t     info,
    output chan_pkg::codeword_t codeword,
    output logic                done
);

    import chan_pkg::*;

    localparam int CNT_W = $clog2(`BCH_K);

    logic              active_q;
    logic [CNT_W-1:0]  cnt_q;
    info_t             msg_q;
    info_t             shift_q;
    rem_t              rem_q;
    rem_t              rem_next;

    assign rem_next = bch_step(rem_q, shift_q[`BCH_K-1]);
    assign codeword = {msg_q, rem_q};   // systematic, message on top

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(`BCH_K - 1);
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == 1) begin
                    active_q <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

    // first bit is divided on the start edge itself
    always_ff @(posedge clk) begin
        if (start) begin
            msg_q   <= info;
            shift_q <= info << 1;
            rem_q   <= bch_step('0, info[`BCH_K-1]);
        end else if (active_q) begin
            shift_q <= shift_q << 1;
            rem_q   <= rem_next;
        end
    end

endmodule

// ==== source/chan_ctrl.sv ====
module chan_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic bch_en,
    input  logic err_en,
    input  logic enc_done,
    input  logic inj_done,
    input  logic chk_done,
    output logic enc_start,
    output logic inj_start,
    output logic chk_start,
    output logic busy,
    output logic done
);

    import chan_pkg::*;

    ctrl_state_t state_q;

    assign busy = (state_q == ENCODE) || (state_q == INJECT) || (state_q == CHECK);
    assign done = (state_q == DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            enc_start <= 1'b0;
            inj_start <= 1'b0;
            chk_start <= 1'b0;
        end else begin
            enc_start <= 1'b0;
            inj_start <= 1'b0;
            chk_start <= 1'b0;
            case (state_q)
                IDLE, DONE: begin
                    // ENCODE is always entered so busy shows for at least a cycle
                    if (start) begin
                        state_q   <= ENCODE;
                        enc_start <= bch_en;
                    end
                end
                ENCODE: begin
                    if (enc_done || !bch_en) begin
                        if (err_en) begin
                            state_q   <= INJECT;
                            inj_start <= 1'b1;
                        end else if (bch_en) begin
                            state_q   <= CHECK;
                            chk_start <= 1'b1;
                        end else begin
                            state_q <= DONE;
                        end
                    end
                end
                INJECT: begin
                    if (inj_done) begin
                        state_q   <= bch_en ? CHECK : DONE;
                        chk_start <= bch_en;
                    end
                end
                CHECK: begin
                    if (chk_done) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== source/chan_pkg.sv ====
`include "chan_macros.svh"

package chan_pkg;

    typedef logic [`DATA_W-1:0]          byte_t;
    typedef logic [`BCH_K-1:0]           info_t;
    typedef logic [`BCH_N-1:0]           codeword_t;
    typedef logic [7:0]                  err_cnt_t;
    typedef logic [`BCH_N-`BCH_K-1:0]    rem_t;      // parity / remainder bits

    typedef enum logic [2:0] {
        IDLE,
        ENCODE,
        INJECT,
        CHECK,
        DONE
    } ctrl_state_t;

    localparam logic [`BCH_N-`BCH_K:0] BCH_GEN_POLY = `BCH_GEN;

    // one step of division by the generator, message bit enters at the top
    function automatic rem_t bch_step(rem_t rem, logic din);
        logic fb;
        fb = din ^ rem[$high(rem)];
        bch_step = {rem[$high(rem)-1:0], 1'b0} ^ (fb ? BCH_GEN_POLY[$high(rem):0] : '0);
    endfunction

endpackage

// ==== source/chan_top.sv ====
`include "chan_macros.svh"

module chan_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      s_axil_awvalid,
    input  logic [`AXI_ADDR_W-1:0]    s_axil_awaddr,
    input  logic [2:0]                s_axil_awprot,
    output logic                      s_axil_awready,
    input  logic                      s_axil_wvalid,
    input  logic [`AXI_DATA_W-1:0]    s_axil_wdata,
    input  logic [`AXI_DATA_W/8-1:0]  s_axil_wstrb,
    output logic                      s_axil_wready,
    input  logic                      s_axil_bready,
    output logic                      s_axil_bvalid,
    output logic [1:0]                s_axil_bresp,
    input  logic                      s_axil_arvalid,
    input  logic [`AXI_ADDR_W-1:0]    s_axil_araddr,
    input  logic [2:0]                s_axil_arprot,
    output logic                      s_axil_arready,
    input  logic                      s_axil_rready,
    output logic                      s_axil_rvalid,
    output logic [`AXI_DATA_W-1:0]    s_axil_rdata,
    output logic [1:0]                s_axil_rresp
);

    logic                start;
    logic                bch_en;
    logic                err_en;
    logic                busy;
    logic                done;
    logic [`DATA_W-1:0]  data_in;
    logic [`DATA_W-1:0]  data_out;
    logic [7:0]          err_cnt;

    logic                enc_start;
    logic                inj_start;
    logic                chk_start;
    logic                enc_done0;
    logic                enc_done1;
    logic                inj_done;
    logic                chk_done0;
    logic                chk_done1;
    logic                nonzero0;
    logic                nonzero1;

    logic [`BCH_N-1:0]   cw0_enc;
    logic [`BCH_N-1:0]   cw1_enc;
    logic [`BCH_N-1:0]   cw0_rx;
    logic [`BCH_N-1:0]   cw1_rx;

    // ------------------------------------------------------------------------
    // register front end and sequencing
    // ------------------------------------------------------------------------
    axil_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awprot  (s_axil_awprot),
        .s_axil_awready (s_axil_awready),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bready  (s_axil_bready),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arprot  (s_axil_arprot),
        .s_axil_arready (s_axil_arready),
        .s_axil_rready  (s_axil_rready),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .busy           (busy),
        .done           (done),
        .err_detected   (nonzero0 | nonzero1),
        .cw0            (cw0_rx),
        .cw1            (cw1_rx),
        .data_out       (data_out),
        .start          (start),
        .bch_en         (bch_en),
        .err_en         (err_en),
        .data_in        (data_in),
        .err_cnt        (err_cnt)
    );

    chan_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .bch_en    (bch_en),
        .err_en    (err_en),
        .enc_done  (enc_done0 & enc_done1),   // both finish on the same cycle
        .inj_done  (inj_done),
        .chk_done  (chk_done0 & chk_done1),
        .enc_start (enc_start),
        .inj_start (inj_start),
        .chk_start (chk_start),
        .busy      (busy),
        .done      (done)
    );

    // ------------------------------------------------------------------------
    // datapath, high nibble on cw0 and low nibble on cw1
    // ------------------------------------------------------------------------
    bch_encoder u_enc0 (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .info     ({1'b0, data_in[7:4]}),
        .codeword (cw0_enc),
        .done     (enc_done0)
    );

    bch_encoder u_enc1 (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .info     ({1'b0, data_in[3:0]}),
        .codeword (cw1_enc),
        .done     (enc_done1)
    );

    error_injector u_inj (
        .clk      (clk),
        .rst      (rst),
        .start    (inj_start),
        .bch_en   (bch_en),
        .err_cnt  (err_cnt),
        .cw0_in   (cw0_enc),
        .cw1_in   (cw1_enc),
        .data_in  (data_in),
        .cw0      (cw0_rx),
        .cw1      (cw1_rx),
        .data_out (data_out),
        .done     (inj_done)
    );

    syndrome_check u_chk0 (
        .clk      (clk),
        .rst      (rst),
        .start    (chk_start),
        .codeword (cw0_rx),
        .nonzero  (nonzero0),
        .done     (chk_done0)
    );

    syndrome_check u_chk1 (
        .clk      (clk),
        .rst      (rst),
        .start    (chk_start),
        .codeword (cw1_rx),
        .nonzero  (nonzero1),
        .done     (chk_done1)
    );

endmodule

// ==== source/error_injector.sv ====
`include "chan_macros.svh"

module error_injector (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                bch_en,
    input  chan_pkg::err_cnt_t  err_cnt,
    input  chan_pkg::codeword_t cw0_in,
    input  chan_pkg::codeword_t cw1_in,
    input  chan_pkg::byte_t     data_in,
    output chan_pkg::codeword_t cw0,
    output chan_pkg::codeword_t cw1,
    output chan_pkg::byte_t     data_out,
    output logic                done
);

    import chan_pkg::*;

    localparam int W      = 2 * `BCH_N;       // both codewords side by side
    localparam int IDX_W  = $clog2(W);
    localparam int NIB_HI = `BCH_N - 2;       // message nibble in the codeword
    localparam int NIB_LO = `BCH_N - `BCH_K;

    logic [15:0]       lfsr_q;
    logic [W-1:0]      word_q;
    logic [W-1:0]      mask_q;
    logic [IDX_W-1:0]  idx;
    logic              idx_ok;
    logic              flip;
    logic              active_q;
    logic              coded_q;
    logic              bypass;
    err_cnt_t          flips_q;
    err_cnt_t          target_q;
    err_cnt_t          limit_new;

    assign idx       = lfsr_q[IDX_W-1:0];
    assign idx_ok    = (coded_q ? (idx < W) : (idx < `DATA_W)) && !mask_q[idx];
    assign flip      = active_q && (flips_q != target_q) && idx_ok;
    assign limit_new = bch_en ? err_cnt_t'(W) : err_cnt_t'(`DATA_W);

    // nothing to inject, words pass straight through
    assign bypass   = (err_cnt == '0);
    assign cw0      = bypass ? cw0_in : word_q[W-1:`BCH_N];
    assign cw1      = bypass ? cw1_in : word_q[`BCH_N-1:0];
    assign data_out = bypass  ? data_in :
                      coded_q ? {word_q[`BCH_N+NIB_HI:`BCH_N+NIB_LO], word_q[NIB_HI:NIB_LO]} :
                                word_q[`DATA_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q   <= `LFSR_SEED;
            active_q <= 1'b0;
            coded_q  <= 1'b0;
            mask_q   <= '0;
            flips_q  <= '0;
            target_q <= '0;
            done     <= 1'b0;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            done   <= 1'b0;
            if (start) begin
                active_q <= 1'b1;
                coded_q  <= bch_en;
                mask_q   <= '0;
                flips_q  <= '0;
                target_q <= (err_cnt > limit_new) ? limit_new : err_cnt;
            end else if (active_q && flips_q == target_q) begin
                active_q <= 1'b0;
                done     <= 1'b1;
            end else if (flip) begin
                mask_q[idx] <= 1'b1;
                flips_q     <= flips_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            word_q <= bch_en ? {cw0_in, cw1_in} : W'(data_in);
        end else if (flip) begin
            word_q[idx] <= ~word_q[idx];
        end
    end

endmodule

// ==== source/syndrome_check.sv ====
`include "chan_macros.svh"

module syndrome_check (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  chan_pkg::codeword_t codeword,
    output logic                nonzero,
    output logic                done
);

    import chan_pkg::*;

    localparam int CNT_W = $clog2(`BCH_N);

    logic              active_q;
    logic [CNT_W-1:0]  cnt_q;
    codeword_t         shift_q;
    rem_t              rem_q;
    rem_t              rem_next;

    // x^10*c(x) mod g is zero exactly when c(x) mod g is
    assign rem_next = bch_step(rem_q, shift_q[`BCH_N-1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            nonzero  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(`BCH_N - 1);
                nonzero  <= 1'b0;
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == 1) begin   // last bit goes in now
                    active_q <= 1'b0;
                    nonzero  <= |rem_next;
                    done     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= codeword << 1;
            rem_q   <= bch_step('0, codeword[`BCH_N-1]);
        end else if (active_q) begin
            shift_q <= shift_q << 1;
            rem_q   <= rem_next;
        end
    end

endmodule

// ==== test/chan_sva.sv ====
module chan_sva (
    input logic        clk,
    input logic        rst,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        busy,
    input logic        done
);

    timeunit 1ns;
    timeprecision 1ps;

    // responses wait for the manager
    a_bvalid_hold : assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold : assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read response changed before rready");

    a_busy_done : assert property (@(posedge clk) disable iff (rst)
        !(busy && done))
        else $error("busy and done both high");

    a_reset_idle : assert property (@(posedge clk) rst |-> !busy && !done)
        else $error("controller not idle in reset");

endmodule

bind chan_top chan_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .bvalid (s_axil_bvalid),
    .bready (s_axil_bready),
    .rvalid (s_axil_rvalid),
    .rready (s_axil_rready),
    .rdata  (s_axil_rdata),
    .busy   (busy),
    .done   (done)
);

// ==== test/tb_chan.sv ====
`include "chan_macros.svh"

module tb_chan;

    timeunit 1ns;
    timeprecision 1ps;

    localparam time DRV_DLY     = 5ns;     // input drive after the rising edge
    localparam int  NUM_RUNS    = 12;      // channel runs and register accesses, rounded up
    localparam int  POLL_MAX    = 500;     // status reads per run
    localparam int  READ_CYCLES = 4;
    localparam int  CYCLE_LIMIT = NUM_RUNS * POLL_MAX * READ_CYCLES;

    logic        clk;
    logic        rst;
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        awready;
    logic        wvalid;
    logic [31:0] wdata;
    logic        wready;
    logic        bready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        arready;
    logic        rready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     errors_before;
    int     cycles;
    string  test_name;

    chan_top DUT (
        .clk(clk), .rst(rst),
        .s_axil_awvalid(awvalid), .s_axil_awaddr(awaddr), .s_axil_awprot(3'b000),
        .s_axil_awready(awready), .s_axil_wvalid(wvalid), .s_axil_wdata(wdata),
        .s_axil_wstrb(4'hF), .s_axil_wready(wready), .s_axil_bready(bready),
        .s_axil_bvalid(bvalid), .s_axil_bresp(bresp), .s_axil_arvalid(arvalid),
        .s_axil_araddr(araddr), .s_axil_arprot(3'b000), .s_axil_arready(arready),
        .s_axil_rready(rready), .s_axil_rvalid(rvalid), .s_axil_rdata(rdata),
        .s_axil_rresp(rresp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    // long division of info * x^10 by the generator
    function automatic logic [14:0] bch_ref(input logic [4:0] info);
        logic [14:0] r;
        r = {info, 10'b0};
        for (int i = 14; i >= 10; i--) begin
            if (r[i]) begin
                r = r ^ (15'(`BCH_GEN) << (i - 10));
            end
        end
        bch_ref = {info, r[9:0]};
    endfunction

    function automatic int count_ones(input logic [14:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 15; i++) begin
            n += v[i];
        end
        count_ones = n;
    endfunction

    // ------------------------------------------------------------------------
    // checks and bookkeeping
    // ------------------------------------------------------------------------
    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: FAILED with %0d errors", test_name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI-lite manager
    // ------------------------------------------------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge clk);
        #DRV_DLY;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_eq("wready with awready", wready, 1'b1);
        @(posedge clk);
        #DRV_DLY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #DRV_DLY;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        #DRV_DLY;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #DRV_DLY;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #DRV_DLY;
        rready = 1'b0;
    endtask

    // write CTRL with start set and poll STATUS until done
    task automatic run_channel(input logic [31:0] ctrl, output logic [31:0] status);
        logic [1:0] resp;
        int         polls;
        axil_write(`REG_CTRL, ctrl | 32'h1, resp);
        polls  = 0;
        status = '0;
        while (!status[0] && polls < POLL_MAX) begin
            axil_read(`REG_STATUS, status, resp);
            polls++;
        end
        if (!status[0]) begin
            $display("done never came after %0d status reads at %0t", polls, $time);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] held;
        logic [31:0] status;
        logic [31:0] cw0;
        logic [31:0] cw1;
        logic [1:0]  resp;
        logic [7:0]  d;
        int          flips;

        seed = 60;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        rst = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;

        begin_test("registers");
        axil_write(`REG_DATA_IN, 32'hA5, resp);
        check_eq("DATA_IN bresp", resp, 2'b00);
        axil_write(`REG_ERR_CNT, 32'h3C, resp);
        axil_read(`REG_DATA_IN, rd, resp);
        check_eq("DATA_IN", rd, 32'hA5);
        axil_read(`REG_ERR_CNT, rd, resp);
        check_eq("ERR_CNT", rd, 32'h3C);
        axil_read(8'h20, rd, resp);
        check_eq("unmapped rresp", resp, 2'b10);
        check_eq("unmapped rdata", rd, 32'h0);
        axil_write(8'h20, 32'h5A, resp);
        check_eq("unmapped bresp", resp, 2'b10);
        axil_read(`REG_DATA_IN, rd, resp);
        check_eq("DATA_IN after bad write", rd, 32'hA5);
        end_test();

        begin_test("pass-through");
        d = $random(seed);
        axil_write(`REG_DATA_IN, d, resp);
        run_channel(32'h0, status);
        axil_read(`REG_DATA_OUT, rd, resp);
        check_eq("DATA_OUT", rd, {24'h0, d});
        end_test();

        begin_test("bch clean");
        d = $random(seed);
        axil_write(`REG_DATA_IN, d, resp);
        run_channel(32'h2, status);
        check_eq("err_detected", status[2], 1'b0);
        axil_read(`REG_CW0, rd, resp);
        check_eq("CW0", rd, {17'h0, bch_ref({1'b0, d[7:4]})});
        axil_read(`REG_CW1, rd, resp);
        check_eq("CW1", rd, {17'h0, bch_ref({1'b0, d[3:0]})});
        axil_read(`REG_DATA_OUT, rd, resp);
        check_eq("DATA_OUT", rd, {24'h0, d});
        end_test();

        begin_test("bch with errors");
        for (int n = 1; n <= 6; n++) begin
            d = $random(seed);
            axil_write(`REG_DATA_IN, d, resp);
            axil_write(`REG_ERR_CNT, n, resp);
            run_channel(32'h6, status);
            check_eq("err_detected", status[2], 1'b1);
            axil_read(`REG_CW0, cw0, resp);
            axil_read(`REG_CW1, cw1, resp);
            flips = count_ones(cw0[14:0] ^ bch_ref({1'b0, d[7:4]}))
                  + count_ones(cw1[14:0] ^ bch_ref({1'b0, d[3:0]}));
            check_eq("flipped bits", flips, n);
        end
        end_test();

        begin_test("uncoded clamp");
        d = $random(seed);
        axil_write(`REG_DATA_IN, d, resp);
        axil_write(`REG_ERR_CNT, 32'd12, resp);
        run_channel(32'h4, status);
        axil_read(`REG_DATA_OUT, rd, resp);
        check_eq("DATA_OUT", rd, {24'h0, ~d});
        end_test();

        begin_test("read back-pressure");
        d = $random(seed);
        axil_write(`REG_DATA_IN, d, resp);
        @(posedge clk);
        #DRV_DLY;
        arvalid = 1'b1;
        araddr  = `REG_DATA_IN;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #DRV_DLY;
        arvalid = 1'b0;
        @(negedge clk);
        held = rdata;
        repeat (5) begin    // rready stays low
            check_eq("rvalid held", rvalid, 1'b1);
            check_eq("rdata held", rdata, held);
            @(negedge clk);
        end
        @(posedge clk);
        #DRV_DLY;
        rready = 1'b1;
        @(negedge clk);
        check_eq("rdata taken", rdata, {24'h0, d});
        @(posedge clk);
        #DRV_DLY;
        rready = 1'b0;
        @(negedge clk);
        check_eq("rvalid cleared", rvalid, 1'b0);
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
